//--- logic/aluPath.sv
`timescale 1ns/10ps
`include "datapath_consts.svh"

module aluPath
    import datapathPkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  wordT  regBusData,
    input  wordT  cSignExt,
    input  logic  yIn,
    input  logic  zIn,
    input  logic  cOut,
    input  logic  zOut,
    input  aluOpT aluOp,
    output wordT  busData
);

    wordT yReg;
    wordT zReg;
    wordT aluResult;

    // Shared bus source select
    always_comb
    begin
        if (zOut)
        begin
            busData = zReg;
        end
        else if (cOut)
        begin
            busData = cSignExt;
        end
        else
        begin
            busData = regBusData;
        end
    end

    // Y is the left operand, the bus the right
    always_comb
    begin
        case (aluOp)
            aluAdd:  aluResult = yReg + busData;
            aluSub:  aluResult = yReg - busData;
            aluAnd:  aluResult = yReg & busData;
            aluOr:   aluResult = yReg | busData;
            default: aluResult = yReg + busData;
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            yReg <= '0;
            zReg <= '0;
        end
        else
        begin
            if (yIn)
            begin
                yReg <= busData;
            end
            if (zIn)
            begin
                zReg <= aluResult;
            end
        end
    end

    // Only one non-register source may own the bus
    assert property (@(posedge clk) disable iff (!rstN) !(cOut && zOut))
    else $error("constant and Z driven onto the bus together");

endmodule

//--- logic/controlSequencer.sv
`timescale 1ns/10ps
`include "datapath_consts.svh"

module controlSequencer
    import datapathPkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  instrValid,
    input  wordT  instrWord,
    output wordT  irWord,
    output logic  busy,
    output logic  gra,
    output logic  grb,
    output logic  grc,
    output logic  rIn,
    output logic  rOut,
    output logic  baOut,
    output logic  yIn,
    output logic  zIn,
    output logic  cOut,
    output logic  zOut,
    output aluOpT aluOp,
    output logic  wbValid
);

    seqStateT state;
    seqStateT stateNext;
    opcodeT   opcode;
    logic     useImm;
    logic     useBase;
    logic     accept;

    assign accept = instrValid && (state == stIdle);
    assign opcode = irWord[`OPCODE_MSB:`OPCODE_LSB];

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            irWord <= '0;
        end
        else if (accept)
        begin
            irWord <= instrWord;
        end
    end

    // Opcode decode
    always_comb
    begin
        aluOp   = aluAdd;
        useImm  = 1'b0;
        useBase = 1'b0;
        case (opcode)
            `OP_ADD:  aluOp = aluAdd;
            `OP_SUB:  aluOp = aluSub;
            `OP_AND:  aluOp = aluAnd;
            `OP_OR:   aluOp = aluOr;
            `OP_ADDI,
            `OP_LA:
            begin
                aluOp   = aluAdd;
                useImm  = 1'b1;
                useBase = 1'b1;
            end
            `OP_ANDI:
            begin
                aluOp   = aluAnd;
                useImm  = 1'b1;
                useBase = 1'b1;
            end
            `OP_ORI:
            begin
                aluOp   = aluOr;
                useImm  = 1'b1;
                useBase = 1'b1;
            end
            // Unknown opcodes run as a three-register add
            default:  aluOp = aluAdd;
        endcase
    end

    always_comb
    begin
        stateNext = state;
        case (state)
            stIdle:     stateNext = accept ? stOperandA : stIdle;
            stOperandA: stateNext = stOperandB;
            stOperandB: stateNext = stWrite;
            stWrite:    stateNext = stIdle;
            default:    stateNext = stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= stIdle;
        end
        else
        begin
            state <= stateNext;
        end
    end

    // All transfer controls come from one block so they switch together
    always_comb
    begin
        gra     = 1'b0;
        grb     = 1'b0;
        grc     = 1'b0;
        rIn     = 1'b0;
        rOut    = 1'b0;
        baOut   = 1'b0;
        yIn     = 1'b0;
        zIn     = 1'b0;
        cOut    = 1'b0;
        zOut    = 1'b0;
        wbValid = 1'b0;
        busy    = (state != stIdle);
        case (state)
            stOperandA:
            begin
                grb   = 1'b1;
                baOut = useBase;
                rOut  = !useBase;
                yIn   = 1'b1;
            end
            stOperandB:
            begin
                grc  = !useImm;
                rOut = !useImm;
                cOut = useImm;
                zIn  = 1'b1;
            end
            stWrite:
            begin
                zOut    = 1'b1;
                gra     = 1'b1;
                rIn     = 1'b1;
                wbValid = 1'b1;
            end
            default:
            begin
                busy = 1'b0;
            end
        endcase
    end

    // No back-pressure, so a strobe during execution is lost
    assert property (@(posedge clk) disable iff (!rstN) instrValid |-> !busy)
    else $warning("instruction strobe dropped while busy");

endmodule

//--- logic/datapathPkg.sv
`include "datapath_consts.svh"

package datapathPkg;

    typedef logic [`WORD_WIDTH-1:0] wordT;
    typedef logic [$clog2(`NUM_REGS)-1:0] regIdxT;
    typedef logic [`NUM_REGS-1:0] regMaskT;
    typedef logic [`OPCODE_MSB-`OPCODE_LSB:0] opcodeT;

    typedef enum logic [1:0]
    {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr
    } aluOpT;

    // Three register-transfer steps after the idle state
    typedef enum logic [1:0]
    {
        stIdle,
        stOperandA,
        stOperandB,
        stWrite
    } seqStateT;

endpackage

//--- logic/datapathTop.sv
`timescale 1ns/10ps
`include "datapath_consts.svh"

module datapathTop
    import datapathPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   instrValid,
    input  wordT   instrWord,
    output logic   busy,
    output logic   wbValid,
    output regIdxT wbReg,
    output wordT   wbData
);

    wordT    irWord;
    wordT    cSignExt;
    wordT    regBusData;
    wordT    busData;
    regMaskT regLoad;
    regMaskT regDrive;
    aluOpT   aluOp;
    logic    gra;
    logic    grb;
    logic    grc;
    logic    rIn;
    logic    rOut;
    logic    baOut;
    logic    yIn;
    logic    zIn;
    logic    cOut;
    logic    zOut;

    controlSequencer sequencer (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instrWord  (instrWord),
        .irWord     (irWord),
        .busy       (busy),
        .gra        (gra),
        .grb        (grb),
        .grc        (grc),
        .rIn        (rIn),
        .rOut       (rOut),
        .baOut      (baOut),
        .yIn        (yIn),
        .zIn        (zIn),
        .cOut       (cOut),
        .zOut       (zOut),
        .aluOp      (aluOp),
        .wbValid    (wbValid)
    );

    selectEncode selEnc (
        .irWord   (irWord),
        .gra      (gra),
        .grb      (grb),
        .grc      (grc),
        .rIn      (rIn),
        .rOut     (rOut),
        .baOut    (baOut),
        .regLoad  (regLoad),
        .regDrive (regDrive),
        .cSignExt (cSignExt)
    );

    registerFile regFile (
        .clk        (clk),
        .rstN       (rstN),
        .regLoad    (regLoad),
        .regDrive   (regDrive),
        .baOut      (baOut),
        .busData    (busData),
        .regBusData (regBusData)
    );

    aluPath alu (
        .clk        (clk),
        .rstN       (rstN),
        .regBusData (regBusData),
        .cSignExt   (cSignExt),
        .yIn        (yIn),
        .zIn        (zIn),
        .cOut       (cOut),
        .zOut       (zOut),
        .aluOp      (aluOp),
        .busData    (busData)
    );

    // Write-back report, bus holds Z during the write step
    assign wbReg  = irWord[`RA_MSB:`RA_LSB];
    assign wbData = busData;

endmodule

//--- logic/datapath_consts.svh
`ifndef DATAPATH_CONSTS_SVH
`define DATAPATH_CONSTS_SVH

`define WORD_WIDTH  32
`define NUM_REGS    16
`define CONST_WIDTH 19

// Instruction word fields
`define OPCODE_MSB 31
`define OPCODE_LSB 27
`define RA_MSB     26
`define RA_LSB     23
`define RB_MSB     22
`define RB_LSB     19
`define RC_MSB     18
`define RC_LSB     15

// Opcode values
`define OP_LA   5'd5
`define OP_ADD  5'd12
`define OP_ADDI 5'd13
`define OP_SUB  5'd14
`define OP_AND  5'd20
`define OP_ANDI 5'd21
`define OP_OR   5'd22
`define OP_ORI  5'd23

`endif

//--- logic/registerFile.sv
`timescale 1ns/10ps
`include "datapath_consts.svh"

module registerFile
    import datapathPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  regMaskT regLoad,
    input  regMaskT regDrive,
    input  logic    baOut,
    input  wordT    busData,
    output wordT    regBusData
);

    wordT regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < `NUM_REGS; i++)
            begin
                if (regLoad[i])
                begin
                    regs[i] <= busData;
                end
            end
        end
    end

    always_comb
    begin
        regBusData = '0;
        for (int i = 0; i < `NUM_REGS; i++)
        begin
            if (regDrive[i])
            begin
                regBusData = regBusData | regs[i];
            end
        end
        // r0 as a base address reads as zero
        if (baOut && regDrive[0])
        begin
            regBusData = '0;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) $onehot0(regLoad))
    else $error("register load vector not one-hot");

    assert property (@(posedge clk) disable iff (!rstN) $onehot0(regDrive))
    else $error("register drive vector not one-hot");

endmodule

//--- logic/selectEncode.sv
`timescale 1ns/10ps
`include "datapath_consts.svh"

module selectEncode
    import datapathPkg::*;
(
    input  wordT    irWord,
    input  logic    gra,
    input  logic    grb,
    input  logic    grc,
    input  logic    rIn,
    input  logic    rOut,
    input  logic    baOut,
    output regMaskT regLoad,
    output regMaskT regDrive,
    output wordT    cSignExt
);

    regIdxT  fieldRa;
    regIdxT  fieldRb;
    regIdxT  fieldRc;
    regIdxT  selIdx;
    regMaskT selOneHot;
    logic    driveEn;

    assign fieldRa = irWord[`RA_MSB:`RA_LSB];
    assign fieldRb = irWord[`RB_MSB:`RB_LSB];
    assign fieldRc = irWord[`RC_MSB:`RC_LSB];

    // Only one field is gated through at a time
    assign selIdx = (fieldRa & {$bits(regIdxT){gra}})
                  | (fieldRb & {$bits(regIdxT){grb}})
                  | (fieldRc & {$bits(regIdxT){grc}});

    always_comb
    begin
        selOneHot = '0;
        for (int i = 0; i < `NUM_REGS; i++)
        begin
            if (selIdx == regIdxT'(i))
            begin
                selOneHot[i] = 1'b1;
            end
        end
    end

    assign driveEn  = rOut | baOut;
    assign regLoad  = selOneHot & {`NUM_REGS{rIn}};
    assign regDrive = selOneHot & {`NUM_REGS{driveEn}};

    // Bit 18 of c2 fills the upper word
    assign cSignExt = {{(`WORD_WIDTH-`CONST_WIDTH){irWord[`CONST_WIDTH-1]}},
                       irWord[`CONST_WIDTH-1:0]};

    // Sequencer must never raise two field selects in the same step
    always_comb
    begin
        assert ($onehot0({gra, grb, grc}))
        else $error("more than one register field selected");
    end

endmodule

//--- run.sh
#!/bin/sh
# Builds the datapath testbench with Verilator, runs it into sim.log and checks the log

verilator --binary --timing --assert --top-module datapathTb -f sources.f -o simv \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log \
    || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0

//--- sources.f
+incdir+logic
logic/datapathPkg.sv
logic/selectEncode.sv
logic/registerFile.sv
logic/aluPath.sv
logic/controlSequencer.sv
logic/datapathTop.sv
tests/clockGen.sv
tests/datapathTb.sv

//--- tests/clockGen.sv
`timescale 1ns/10ps

module clockGen
(
    output logic clk,
    output logic rstN
);

    // 100 ns period
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    // Released on a falling edge, clear of the rising edge
    initial
    begin
        rstN = 1'b0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
    end

endmodule

//--- tests/datapathTb.sv
`timescale 1ns/10ps
`include "datapath_consts.svh"

module datapathTb
    import datapathPkg::*;
();

    localparam int NUM_CLEAR     = 16;
    localparam int NUM_PRELOAD   = 16;
    localparam int NUM_THREE_REG = 200;
    localparam int NUM_IMM       = 100;
    localparam int NUM_LA        = 40;
    localparam int NUM_R0_ROUNDS = 4;
    localparam int NUM_DROPS     = 6;
    // A drop round is a strobe, a dropped strobe and a readback
    localparam int TOTAL_INSTRS  = NUM_CLEAR + NUM_PRELOAD + NUM_THREE_REG + NUM_IMM
                                 + NUM_LA + 2 * NUM_R0_ROUNDS + 3 * NUM_DROPS;
    localparam int CYCLE_LIMIT   = 4 * TOTAL_INSTRS + 50;
    localparam int WB_WAIT_LIMIT = 8;

    logic   clk;
    logic   rstN;
    logic   instrValid;
    wordT   instrWord;
    logic   busy;
    logic   wbValid;
    regIdxT wbReg;
    wordT   wbData;

    int   seed = 57;
    int   cycleCount = 0;
    int   testErrors = 0;
    int   passCount = 0;
    int   failCount = 0;
    wordT model [`NUM_REGS];

    clockGen clocks (
        .clk  (clk),
        .rstN (rstN)
    );

    datapathTop UUT (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instrWord  (instrWord),
        .busy       (busy),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT)
        begin
            $display("simulation timed out after %0d cycles", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    function automatic wordT randWord();
        randWord = $random(seed);
    endfunction

    function automatic wordT regInstr(opcodeT op, regIdxT ra, regIdxT rb, regIdxT rc);
        regInstr = {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic wordT immInstr(opcodeT op, regIdxT ra, regIdxT rb, logic [18:0] c2);
        immInstr = {op, ra, rb, c2};
    endfunction

    // Reference model of one instruction on the register array
    function automatic wordT expectedResult(wordT instr);
        opcodeT      op;
        regIdxT      rb;
        regIdxT      rc;
        logic [18:0] c2;
        wordT        a;
        wordT        b;
        op = instr[`OPCODE_MSB:`OPCODE_LSB];
        rb = instr[`RB_MSB:`RB_LSB];
        rc = instr[`RC_MSB:`RC_LSB];
        c2 = instr[`CONST_WIDTH-1:0];
        case (op)
            `OP_LA, `OP_ADDI, `OP_ANDI, `OP_ORI:
            begin
                // Base register r0 counts as zero
                a = (rb == 4'd0) ? 32'd0 : model[rb];
                b = c2[18] ? {13'h1fff, c2} : {13'h0000, c2};
            end
            default:
            begin
                a = model[rb];
                b = model[rc];
            end
        endcase
        case (op)
            `OP_SUB:                    expectedResult = a - b;
            `OP_AND, `OP_ANDI:          expectedResult = a & b;
            `OP_OR, `OP_ORI:            expectedResult = a | b;
            default:                    expectedResult = a + b;
        endcase
    endfunction

    task automatic reportProblem(input string testName, input string msg);
        $display("%s: %s", testName, msg);
        testErrors++;
    endtask

    task automatic checkReg(input string testName, input regIdxT expected, input regIdxT actual);
        if (expected !== actual)
        begin
            $display("error %s: write-back register expected r%0d, actual r%0d",
                     testName, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkWord(input string testName, input wordT expected, input wordT actual);
        if (expected !== actual)
        begin
            $display("error %s: write-back data expected %h, actual %h",
                     testName, expected, actual);
            testErrors++;
        end
    endtask

    task automatic startTest();
        testErrors = 0;
    endtask

    task automatic finishTest(input string testName);
        if (testErrors == 0)
        begin
            $display("test %s passed", testName);
            passCount++;
        end
        else
        begin
            $display("test %s failed with %0d errors", testName, testErrors);
            failCount++;
        end
    endtask

    // Starts and ends on a falling edge, four cycles per instruction
    task automatic runInstr(input string testName, input wordT instr,
                            input logic injectDrop, input wordT dropWord);
        wordT   expData;
        regIdxT expReg;
        int     waitCycles;
        expData = expectedResult(instr);
        expReg  = instr[`RA_MSB:`RA_LSB];
        if (busy)
        begin
            reportProblem(testName, "DUT still busy when a new instruction was due");
        end
        instrValid = 1'b1;
        instrWord  = instr;
        @(negedge clk);
        waitCycles = 1;
        if (injectDrop)
        begin
            if (!busy)
            begin
                reportProblem(testName, "busy low while an instruction is running");
            end
            instrWord = dropWord;
            @(negedge clk);
            waitCycles = 2;
        end
        instrValid = 1'b0;
        instrWord  = '0;
        while (!wbValid && waitCycles < WB_WAIT_LIMIT)
        begin
            @(negedge clk);
            waitCycles++;
        end
        if (!wbValid)
        begin
            reportProblem(testName, "no write-back strobe after the instruction");
        end
        else
        begin
            if (waitCycles != 3)
            begin
                reportProblem(testName, "write-back strobe came at the wrong cycle");
            end
            checkReg(testName, expReg, wbReg);
            checkWord(testName, expData, wbData);
        end
        model[expReg] = expData;
        @(negedge clk);
        if (busy || wbValid)
        begin
            reportProblem(testName, "DUT did not return to idle after write-back");
        end
    endtask

    task automatic watchIdle(input string testName, input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            if (wbValid)
            begin
                reportProblem(testName, "extra write-back strobe from a dropped instruction");
            end
        end
    endtask

    initial
    begin
        wordT        r;
        opcodeT      op;
        regIdxT      ra;
        regIdxT      rb;
        logic [18:0] c2;
        instrValid = 1'b0;
        instrWord  = '0;
        for (int i = 0; i < `NUM_REGS; i++)
        begin
            model[i] = '0;
        end
        @(posedge rstN);
        @(negedge clk);

        startTest();
        if (busy || wbValid)
        begin
            reportProblem("resetClear", "busy or wbValid high after reset");
        end
        for (int i = 0; i < NUM_CLEAR; i++)
        begin
            ra = regIdxT'(i);
            if (i == 0)
            begin
                // Read r0 through rOut since a base r0 is always zero
                runInstr("resetClear", regInstr(`OP_OR, ra, ra, ra), 1'b0, '0);
            end
            else
            begin
                runInstr("resetClear", immInstr(`OP_ANDI, ra, ra, 19'h7ffff), 1'b0, '0);
            end
        end
        finishTest("resetClear");

        startTest();
        // Nonzero contents first, or every result stays zero
        for (int i = 0; i < NUM_PRELOAD; i++)
        begin
            r = randWord();
            runInstr("threeRegister", immInstr(`OP_ADDI, regIdxT'(i), 4'd0, r[18:0]), 1'b0, '0);
        end
        for (int i = 0; i < NUM_THREE_REG; i++)
        begin
            r = randWord();
            case (r[1:0])
                2'd0:    op = `OP_ADD;
                2'd1:    op = `OP_SUB;
                2'd2:    op = `OP_AND;
                default: op = `OP_OR;
            endcase
            runInstr("threeRegister", regInstr(op, r[7:4], r[11:8], r[15:12]), 1'b0, '0);
        end
        finishTest("threeRegister");

        startTest();
        for (int i = 0; i < NUM_IMM; i++)
        begin
            r = randWord();
            case (r[31:30])
                2'd0:    op = `OP_ANDI;
                2'd1:    op = `OP_ORI;
                default: op = `OP_ADDI;
            endcase
            c2     = r[18:0];
            c2[18] = i[0];
            runInstr("immediate", immInstr(op, r[22:19], r[26:23], c2), 1'b0, '0);
        end
        finishTest("immediate");

        startTest();
        for (int i = 0; i < NUM_LA; i++)
        begin
            r  = randWord();
            rb = (i < NUM_LA / 2) ? 4'd0 : r[22:19];
            if (i >= NUM_LA / 2 && rb == 4'd0)
            begin
                rb = 4'd1;
            end
            runInstr("loadAddress", immInstr(`OP_LA, r[26:23], rb, r[18:0]), 1'b0, '0);
        end
        finishTest("loadAddress");

        startTest();
        for (int i = 0; i < NUM_R0_ROUNDS; i++)
        begin
            r  = randWord();
            c2 = r[18:0] | 19'd1;
            runInstr("r0Storage", immInstr(`OP_ADDI, 4'd0, 4'd0, c2), 1'b0, '0);
            runInstr("r0Storage", regInstr(`OP_ADD, r[26:23], 4'd0, 4'd0), 1'b0, '0);
        end
        finishTest("r0Storage");

        startTest();
        for (int i = 0; i < NUM_DROPS; i++)
        begin
            r  = randWord();
            ra = r[7:4];
            rb = ra + 4'd1;
            runInstr("droppedStrobe", regInstr(`OP_ADD, ra, r[11:8], r[15:12]), 1'b1,
                     immInstr(`OP_ORI, rb, 4'd0, 19'h7ffff));
            watchIdle("droppedStrobe", 3);
            // Target of the dropped strobe must still hold its old value
            runInstr("droppedStrobe", regInstr(`OP_OR, rb, rb, rb), 1'b0, '0);
        end
        finishTest("droppedStrobe");

        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
